// ==== clkgen_pkg.sv ====
//##############################
// shared widths, register map and FSM encoding
// dividers are 8 bit, 0 is illegal for all three
// nco threshold is divin * divout in 16 bits
//##############################

`default_nettype none

package clkgen_pkg;

   //##############################
   // divider widths and types
   //##############################
   localparam int DIVINW  = 8;               // reference divider N
   localparam int DIVFBW  = 8;               // feedback divider M
   localparam int DIVOUTW = 8;               // output divider
   localparam int THRW    = DIVINW + DIVOUTW; // holds divin * divout

   typedef logic [DIVINW-1:0]  divin_t;
   typedef logic [DIVFBW-1:0]  divfb_t;
   typedef logic [DIVOUTW-1:0] divout_t;
   typedef logic [THRW-1:0]    thr_t;        // nco wrap threshold

   //##############################
   // register port
   //##############################
   localparam int ADDRW = 2;
   localparam int DATAW = 8;

   typedef logic [ADDRW-1:0] reg_addr_t;
   typedef logic [DATAW-1:0] reg_data_t;

   localparam reg_addr_t REG_DIVIN  = 2'd0;
   localparam reg_addr_t REG_DIVFB  = 2'd1;
   localparam reg_addr_t REG_DIVOUT = 2'd2;
   localparam reg_addr_t REG_CTRL   = 2'd3;

   // ctrl bit positions
   localparam int CTRL_EN     = 0; // rw, pll enable
   localparam int CTRL_FBYP   = 1; // rw, force bypass
   localparam int CTRL_LOCKED = 2; // ro
   localparam int CTRL_OVR    = 3; // ro, divfb above threshold

   //##############################
   // lock model and sequencer
   //##############################
   localparam int LOCK_CYCLES = 16;                      // cycles to freqlock
   localparam int LOCKW       = $clog2(LOCK_CYCLES + 1); // counter must hold 16

   typedef logic [LOCKW-1:0] lock_cnt_t;

   typedef enum logic [1:0] {
      SEQ_OFF,
      SEQ_START,      // one cycle, restart pulse
      SEQ_WAIT_LOCK,
      SEQ_LOCKED
   } seq_state_e;

endpackage

`default_nettype wire

// ==== pll_cfg_if.sv ====
//##############################
// divider settings and control levels
// all six signals are driven by the register block
// cfg_change is a one cycle pulse, the rest are levels
//##############################

`default_nettype none

interface pll_cfg_if;
   import clkgen_pkg::*;

   divin_t  divin;        // N
   divfb_t  divfb;        // M
   divout_t divout;
   logic    en;           // ctrl enable bit
   logic    force_bypass; // ctrl fbyp bit
   logic    cfg_change;   // pulse after accepted config write

   // register side drives everything
   modport regs (
      output divin, divfb, divout,
      output en, force_bypass, cfg_change
   );

   // sequencer only needs the control levels
   modport seq (
      input en, force_bypass, cfg_change
   );

   // pll model only needs the dividers
   modport model (
      input divin, divfb, divout
   );

endinterface

`default_nettype wire

// ==== pll_regs.sv ====
//##############################
// write strobe register block
// wr is a single cycle strobe, no handshake
// zero writes to a divider are dropped silently
// rdata is combinational from addr
//##############################

`default_nettype none

module pll_regs (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wr,        // write strobe
   input  clkgen_pkg::reg_addr_t addr,
   input  clkgen_pkg::reg_data_t wdata,
   output clkgen_pkg::reg_data_t rdata,
   input  logic                  locked,    // from sequencer
   input  logic                  overrange, // from pll model
   pll_cfg_if.regs               cfg
);
   import clkgen_pkg::*;

   divin_t    divin_r;
   divfb_t    divfb_r;
   divout_t   divout_r;
   logic      en_r;
   logic      fbyp_r;
   logic      cfg_change_r;
   logic      div_sel;  // addr hits one of the dividers
   logic      div_ok;   // legal divider write
   logic      en_rise;  // enable going 0 -> 1
   reg_data_t ctrl_rd;

   //##############################
   // write decode
   //##############################
   assign div_sel = (addr == REG_DIVIN) || (addr == REG_DIVFB) || (addr == REG_DIVOUT);
   assign div_ok  = wr && div_sel && (wdata != '0);   // 0 is illegal for N, M, divout
   assign en_rise = wr && (addr == REG_CTRL) && wdata[CTRL_EN] && !en_r;

   always_ff @(posedge clk) begin
      if (reset) begin
         divin_r      <= divin_t'(1);
         divfb_r      <= divfb_t'(1);
         divout_r     <= divout_t'(1);
         en_r         <= 1'b0;
         fbyp_r       <= 1'b0;
         cfg_change_r <= 1'b0;
      end else begin
         if (div_ok) begin
            case (addr)
               REG_DIVIN:  divin_r  <= divin_t'(wdata);
               REG_DIVFB:  divfb_r  <= divfb_t'(wdata);
               REG_DIVOUT: divout_r <= divout_t'(wdata);
               default: ;                              // ctrl handled below
            endcase
         end
         if (wr && (addr == REG_CTRL)) begin
            en_r   <= wdata[CTRL_EN];
            fbyp_r <= wdata[CTRL_FBYP];                // status bits ignored on write
         end
         cfg_change_r <= div_ok || en_rise;            // one cycle pulse
      end
   end

   //##############################
   // readback
   //##############################
   always_comb begin
      ctrl_rd              = '0;
      ctrl_rd[CTRL_EN]     = en_r;
      ctrl_rd[CTRL_FBYP]   = fbyp_r;
      ctrl_rd[CTRL_LOCKED] = locked;
      ctrl_rd[CTRL_OVR]    = overrange;
      case (addr)
         REG_DIVIN:  rdata = reg_data_t'(divin_r);
         REG_DIVFB:  rdata = reg_data_t'(divfb_r);
         REG_DIVOUT: rdata = reg_data_t'(divout_r);
         default:    rdata = ctrl_rd;
      endcase
   end

   // config out to sequencer and model
   assign cfg.divin        = divin_r;
   assign cfg.divfb        = divfb_r;
   assign cfg.divout       = divout_r;
   assign cfg.en           = en_r;
   assign cfg.force_bypass = fbyp_r;
   assign cfg.cfg_change   = cfg_change_r;

endmodule

`default_nettype wire

// ==== pll_seq.sv ====
//##############################
// enable and relock sequencer
// output stays in bypass until SEQ_LOCKED
// any cfg_change while on forces a full relock
// en low drops to off from every state
//##############################

`default_nettype none

module pll_seq (
   input  logic    clk,
   input  logic    reset,
   pll_cfg_if.seq  cfg,
   input  logic    freqlock,    // from pll model
   output logic    pll_restart, // one cycle, clears model
   output logic    pll_run,     // nco advances
   output logic    bypass,      // drives bypass_active
   output logic    locked
);
   import clkgen_pkg::*;

   seq_state_e state;
   seq_state_e state_nxt;

   //##############################
   // next state
   //##############################
   always_comb begin
      state_nxt = state;
      if (!cfg.en) begin
         state_nxt = SEQ_OFF;                  // disable wins over everything
      end else begin
         case (state)
            SEQ_OFF: begin
               state_nxt = SEQ_START;          // en seen high
            end
            SEQ_START: begin
               if (cfg.cfg_change)
                  state_nxt = SEQ_START;       // restart again
               else
                  state_nxt = SEQ_WAIT_LOCK;
            end
            SEQ_WAIT_LOCK: begin
               if (cfg.cfg_change)
                  state_nxt = SEQ_START;
               else if (freqlock)
                  state_nxt = SEQ_LOCKED;
            end
            SEQ_LOCKED: begin
               if (cfg.cfg_change)
                  state_nxt = SEQ_START;       // reconfig, relock
            end
            default: state_nxt = SEQ_OFF;
         endcase
      end
   end

   always_ff @(posedge clk) begin
      if (reset)
         state <= SEQ_OFF;
      else
         state <= state_nxt;
   end

   //##############################
   // state decode
   //##############################
   assign pll_restart = (state == SEQ_START);
   assign pll_run     = (state == SEQ_LOCKED);
   assign locked      = pll_run;                         // same level by definition

   // bypass unless locked and not forced
   assign bypass = !((state == SEQ_LOCKED) && !cfg.force_bypass);

endmodule

`default_nettype wire

// ==== pll_model.sv ====
//##############################
// behavioral pll as an nco in the clk domain
// tick rate is divfb / (divin * divout) per cycle
// lock is a plain counter, no analog behavior
// clkout_tick is a strobe, not a real clock
//##############################

`default_nettype none

module pll_model (
   input  logic     clk,
   input  logic     reset,
   pll_cfg_if.model cfg,
   input  logic     pll_restart, // clears acc and lock count
   input  logic     pll_run,     // nco advance enable
   input  logic     bypass,
   output logic     freqlock,
   output logic     overrange,   // divfb above threshold
   output logic     clkout_tick
);
   import clkgen_pkg::*;

   thr_t      thr;        // divin * divout
   thr_t      acc;        // phase accumulator
   thr_t      sum;        // acc + divfb
   thr_t      fb_ext;
   lock_cnt_t lock_cnt;
   logic      tick;

   //##############################
   // nco
   //##############################
   assign fb_ext    = thr_t'(cfg.divfb);
   assign thr       = thr_t'(cfg.divin) * thr_t'(cfg.divout); // max 255*255 fits 16b
   assign sum       = acc + fb_ext;       // acc < thr so no wrap
   assign overrange = fb_ext > thr;

   // tick in the cycle where the running sum reaches thr
   assign tick = pll_run && (sum >= thr);   // overrange sums always reach thr

   always_ff @(posedge clk) begin
      if (reset || pll_restart) begin
         acc <= '0;
      end else if (pll_run) begin
         if (overrange)
            acc <= '0;              // every run cycle ticks
         else if (sum >= thr)
            acc <= sum - thr;       // wrap
         else
            acc <= sum;
      end
   end

   //##############################
   // lock counter
   //##############################
   always_ff @(posedge clk) begin
      if (reset || pll_restart)
         lock_cnt <= '0;
      else if (lock_cnt != lock_cnt_t'(LOCK_CYCLES))
         lock_cnt <= lock_cnt + 1'b1;    // saturates
   end

   assign freqlock = (lock_cnt == lock_cnt_t'(LOCK_CYCLES));

   //##############################
   // output mux
   //##############################
   // bypass passes the reference, one tick per cycle
   assign clkout_tick = bypass ? 1'b1 : tick;

endmodule

`default_nettype wire

// ==== clkgen_top.sv ====
//##############################
// clock generation subsystem top
// single clock domain, sync active high reset
// register port uses wr strobe, no handshake
// clkout_tick is 1 every cycle while bypass_active
//##############################

`default_nettype none

module clkgen_top (
   input  logic                  clk,
   input  logic                  reset,
   input  logic                  wr,
   input  clkgen_pkg::reg_addr_t addr,
   input  clkgen_pkg::reg_data_t wdata,
   output clkgen_pkg::reg_data_t rdata,
   output logic                  clkout_tick,
   output logic                  locked,
   output logic                  bypass_active
);

   logic pll_restart;
   logic pll_run;
   logic freqlock;
   logic overrange;

   pll_cfg_if cfg_i ();                 // regs -> seq, model

   pll_regs pll_regs_i (
      .clk       (clk),
      .reset     (reset),
      .wr        (wr),
      .addr      (addr),
      .wdata     (wdata),
      .rdata     (rdata),
      .locked    (locked),
      .overrange (overrange),
      .cfg       (cfg_i)
   );

   pll_seq pll_seq_i (
      .clk         (clk),
      .reset       (reset),
      .cfg         (cfg_i),
      .freqlock    (freqlock),
      .pll_restart (pll_restart),
      .pll_run     (pll_run),
      .bypass      (bypass_active),  // bypass decision lives in seq
      .locked      (locked)
   );

   pll_model pll_model_i (
      .clk         (clk),
      .reset       (reset),
      .cfg         (cfg_i),
      .pll_restart (pll_restart),
      .pll_run     (pll_run),
      .bypass      (bypass_active),
      .freqlock    (freqlock),
      .overrange   (overrange),
      .clkout_tick (clkout_tick)
   );

endmodule

`default_nettype wire

// ==== tb_clkgen.sv ====
//##############################
// testbench for the clkgen subsystem
// inputs driven on rising edge, outputs sampled on falling edge
// tick windows start at the first cycle locked is high
//##############################

`default_nettype none

module tb_clkgen;
   timeunit 1ns;
   timeprecision 1ps;
   import clkgen_pkg::*;

   localparam int LOCK_TIMEOUT = 200; // cycles per wait for locked
   localparam int K_LOCKED     = 256; // locked cycles per tick window

   logic      clk;
   logic      reset;
   logic      wr;
   reg_addr_t addr;
   reg_data_t wdata;
   reg_data_t rdata;
   logic      clkout_tick;
   logic      locked;
   logic      bypass_active;

   integer seed;
   int     errors;
   int     checks;
   int     tests;
   int     test_err_start;
   string  test_name;

   clkgen_top clkgen_top_i (
      .clk           (clk),
      .reset         (reset),
      .wr            (wr),
      .addr          (addr),
      .wdata         (wdata),
      .rdata         (rdata),
      .clkout_tick   (clkout_tick),
      .locked        (locked),
      .bypass_active (bypass_active)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;   // 40 ns period
   end

   //##############################
   // reference model
   //##############################
   // ticks in the first k locked cycles, nco law floor(k*divfb/thr)
   function automatic thr_t expected_ticks(input divin_t divin, input divfb_t divfb,
                                           input divout_t divout, input int k);
      int thr;
      int fb;
      int n;
      thr = int'(divin) * int'(divout);
      fb  = int'(divfb);
      if (fb > thr)
         n = k;                 // overrange, tick every run cycle
      else
         n = (k * fb) / thr;
      return thr_t'(n);
   endfunction

   // ctrl register image from its bit map
   function automatic reg_data_t ctrl_value(input logic en, input logic fbyp,
                                            input logic lck, input logic ovr);
      reg_data_t v;
      v              = '0;
      v[CTRL_EN]     = en;
      v[CTRL_FBYP]   = fbyp;
      v[CTRL_LOCKED] = lck;
      v[CTRL_OVR]    = ovr;
      return v;
   endfunction

   //##############################
   // compare tasks
   //##############################
   task automatic check_data(input string name, input reg_data_t exp, input reg_data_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[ERROR] %s expected 0x%02h actual 0x%02h", name, exp, act);
      end
   endtask

   task automatic check_count(input string name, input thr_t exp, input thr_t act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[ERROR] %s expected %0d actual %0d", name, exp, act);
      end
   endtask

   task automatic check_level(input string name, input logic exp, input logic act);
      checks++;
      if (act !== exp) begin
         errors++;
         $display("[ERROR] %s expected %0b actual %0b", name, exp, act);
      end
   endtask

   task automatic start_test(input string name);
      test_name      = name;
      test_err_start = errors;
      tests++;
   endtask

   task automatic end_test();
      if (errors == test_err_start)
         $display("test %s: ok", test_name);
      else
         $display("test %s: failed, %0d errors", test_name, errors - test_err_start);
   endtask

   //##############################
   // bus and wait tasks
   //##############################
   task automatic write_reg(input reg_addr_t a, input reg_data_t d);
      @(posedge clk);
      wr    <= 1'b1;
      addr  <= a;
      wdata <= d;
      @(posedge clk);          // stored at this edge
      wr    <= 1'b0;
   endtask

   task automatic read_reg(input reg_addr_t a, output reg_data_t d);
      @(posedge clk);
      addr <= a;
      @(negedge clk);          // rdata is combinational
      d = rdata;
   endtask

   // returns on the falling edge where locked first matches level
   task automatic wait_locked(input logic level, input string name);
      int  n;
      bit  seen;
      n    = 0;
      seen = 1'b0;
      while (!seen && n < LOCK_TIMEOUT) begin
         @(negedge clk);
         n++;
         if (locked === level)
            seen = 1'b1;
      end
      if (!seen) begin
         errors++;
         $display("%s: locked did not go to %0b within %0d cycles", name, level, LOCK_TIMEOUT);
      end
   endtask

   // caller sits on a falling edge, that cycle is the first counted
   task automatic count_window(input int k, output thr_t ticks, output thr_t byp_n,
                               output thr_t lock_n);
      ticks  = '0;
      byp_n  = '0;
      lock_n = '0;
      for (int i = 0; i < k; i++) begin
         if (i > 0)
            @(negedge clk);
         ticks  = ticks + thr_t'(clkout_tick);
         byp_n  = byp_n + thr_t'(bypass_active);
         lock_n = lock_n + thr_t'(locked);
      end
   endtask

   // disable, load dividers, enable, then wait for lock
   task automatic configure_and_lock(input divin_t di, input divfb_t fb, input divout_t dout,
                                     input string name);
      write_reg(REG_CTRL, ctrl_value(1'b0, 1'b0, 1'b0, 1'b0));
      write_reg(REG_DIVIN, reg_data_t'(di));
      write_reg(REG_DIVFB, reg_data_t'(fb));
      write_reg(REG_DIVOUT, reg_data_t'(dout));
      write_reg(REG_CTRL, ctrl_value(1'b1, 1'b0, 1'b0, 1'b0));
      wait_locked(1'b1, name);
   endtask

   //##############################
   // test sequence
   //##############################
   initial begin
      reg_data_t rd;
      thr_t      ticks;
      thr_t      byp_n;
      thr_t      lock_n;
      divin_t    di;
      divfb_t    fb;
      divout_t   dout;
      int        thr_i;
      seed   = 30;
      errors = 0;
      checks = 0;
      tests  = 0;
      reset  = 1'b1;
      wr     = 1'b0;
      addr   = '0;
      wdata  = '0;
      repeat (8) @(posedge clk);
      reset <= 1'b0;

      start_test("reset values");
      read_reg(REG_DIVIN, rd);
      check_data("reset divin", 8'd1, rd);
      read_reg(REG_DIVFB, rd);
      check_data("reset divfb", 8'd1, rd);
      read_reg(REG_DIVOUT, rd);
      check_data("reset divout", 8'd1, rd);
      read_reg(REG_CTRL, rd);
      check_data("reset ctrl", 8'd0, rd);
      check_level("reset locked", 1'b0, locked);
      check_level("reset bypass_active", 1'b1, bypass_active);
      end_test();

      start_test("zero divider rejection");
      write_reg(REG_DIVIN, 8'd3);
      write_reg(REG_DIVFB, 8'd5);
      write_reg(REG_DIVOUT, 8'd7);
      write_reg(REG_DIVIN, 8'd0);  // all three dropped
      write_reg(REG_DIVFB, 8'd0);
      write_reg(REG_DIVOUT, 8'd0);
      read_reg(REG_DIVIN, rd);
      check_data("zero divin", 8'd3, rd);
      read_reg(REG_DIVFB, rd);
      check_data("zero divfb", 8'd5, rd);
      read_reg(REG_DIVOUT, rd);
      check_data("zero divout", 8'd7, rd);
      end_test();

      start_test("bypass before enable");
      @(negedge clk);
      count_window(64, ticks, byp_n, lock_n);
      check_count("bypass ticks", thr_t'(64), ticks);
      check_count("bypass locked cycles", thr_t'(0), lock_n);
      end_test();

      start_test("ratio after lock");
      for (int s = 0; s < 8; s++) begin
         di    = divin_t'(1 + ({$random(seed)} % 16));
         dout  = divout_t'(1 + ({$random(seed)} % 8));
         thr_i = int'(di) * int'(dout);                  // at most 128
         fb    = divfb_t'(1 + ({$random(seed)} % thr_i)); // legal, not overrange
         configure_and_lock(di, fb, dout, $sformatf("ratio set %0d", s));
         count_window(K_LOCKED, ticks, byp_n, lock_n);
         check_count($sformatf("ratio set %0d ticks", s),
                     expected_ticks(di, fb, dout, K_LOCKED), ticks);
         check_count($sformatf("ratio set %0d bypass cycles", s), thr_t'(0), byp_n);
         read_reg(REG_CTRL, rd);
         check_data($sformatf("ratio set %0d ctrl", s),
                    ctrl_value(1'b1, 1'b0, 1'b1, 1'b0), rd);
      end
      end_test();

      start_test("relock on reconfiguration");
      configure_and_lock(8'd5, 8'd7, 8'd4, "relock first lock");
      write_reg(REG_DIVFB, 8'd13);          // new M while locked
      wait_locked(1'b0, "relock drop");
      wait_locked(1'b1, "relock return");
      count_window(K_LOCKED, ticks, byp_n, lock_n);
      check_count("relock ticks", expected_ticks(8'd5, 8'd13, 8'd4, K_LOCKED), ticks);
      end_test();

      start_test("force bypass and overrange");
      write_reg(REG_CTRL, ctrl_value(1'b1, 1'b1, 1'b0, 1'b0));
      @(negedge clk);
      count_window(64, ticks, byp_n, lock_n);
      check_count("fbyp ticks", thr_t'(64), ticks);
      check_count("fbyp bypass cycles", thr_t'(64), byp_n);
      check_count("fbyp locked cycles", thr_t'(64), lock_n);  // no relock
      write_reg(REG_CTRL, ctrl_value(1'b1, 1'b0, 1'b0, 1'b0));
      configure_and_lock(8'd2, 8'd20, 8'd3, "overrange lock");  // 20 > 6
      count_window(K_LOCKED, ticks, byp_n, lock_n);
      check_count("overrange ticks", expected_ticks(8'd2, 8'd20, 8'd3, K_LOCKED), ticks);
      read_reg(REG_CTRL, rd);
      check_data("overrange ctrl", ctrl_value(1'b1, 1'b0, 1'b1, 1'b1), rd);
      end_test();

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("TB PASSED");
      else
         $display("TB FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== clkgen.f ====
clkgen_pkg.sv
pll_cfg_if.sv
pll_regs.sv
pll_seq.sv
pll_model.sv
clkgen_top.sv
tb_clkgen.sv

// ==== Makefile ====
# Verilator flow for the clkgen subsystem
# pass or fail comes from the pass line in the log

TOP = tb_clkgen
LOG = sim.log

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --top-module $(TOP) -f clkgen.f

run: build
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -qx "TB PASSED" $(LOG)

lint:
	verilator --lint-only -Wall --timing --top-module clkgen_top -f clkgen.f

clean:
	rm -rf obj_dir $(LOG)
